//--- hdl/data_forward.sv
// Forwarding path: offers each arriving data prefix to the PIT and streams or drops its payload
`timescale 1ns/1ps
`default_nettype none

module data_forward
    import fib_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              data_ready,
    input  prefix_t          data_in_prefix,
    input  len_t             data_in_len,
    input  wire              rejected,
    input  wire              start_send_to_pit,
    input  wire [DATA_W-1:0] data_in,
    output prefix_t          pit_out_prefix,
    output len_t             pit_out_len,
    output logic             prefix_ready,
    output logic [DATA_W-1:0] out_data,
    output logic             out_valid,
    output logic             out_last
);

    typedef enum logic [1:0] {
        s_idle,
        s_offer,
        s_wait,
        s_xfer
    } state_t;

    state_t state;

    // Bytes already sent in the current transfer
    logic [BYTE_CNT_W-1:0] byte_cnt;

    // Final byte of the fixed-size block
    assign out_last = (state == s_xfer) && (byte_cnt == BYTE_CNT_W'(DATA_BYTES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (data_ready) begin
                        state <= s_offer;
                    end
                end
                s_offer: begin
                    state <= s_wait;
                end
                s_wait: begin
                    byte_cnt <= '0;
                    // A rejection drops the packet even with a start strobe
                    if (rejected) begin
                        state <= s_idle;
                    end else if (start_send_to_pit) begin
                        state <= s_xfer;
                    end
                end
                s_xfer: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (out_last) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // Prefix held for the offer to the PIT
    always_ff @(posedge clk) begin
        if (state == s_idle && data_ready) begin
            pit_out_prefix <= data_in_prefix;
            pit_out_len <= data_in_len;
        end
    end

    // Each output byte is the input byte of the cycle before
    always_ff @(posedge clk) begin
        out_data <= data_in;
    end

    assign prefix_ready = (state == s_offer);
    assign out_valid = (state == s_xfer);

endmodule

`default_nettype wire

//--- hdl/fib_insert.sv
// Insertion path of the FIB: hashes each arriving data prefix and sets its valid bit
`timescale 1ns/1ps
`default_nettype none

module fib_insert
    import fib_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     table_ready,
    input  wire     data_ready,
    input  prefix_t data_in_prefix,
    input  len_t    data_in_len,
    output logic    wr_en,
    output hash_t   wr_hash,
    output len_t    wr_len
);

    typedef enum logic [1:0] {
        s_idle,
        s_hash,
        s_write
    } state_t;

    state_t state;

    // Entry held while its hash is computed
    prefix_t ins_prefix;
    len_t ins_len;
    hash_t ins_hash;

    // Strobe in T, hash in T+1, write in T+2
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    // Length 0 carries no prefix bits, nothing to record
                    if (data_ready && table_ready && data_in_len != '0) begin
                        state <= s_hash;
                    end
                end
                s_hash: begin
                    state <= s_write;
                end
                s_write: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // Capture on the strobe, held until the write is done
    always_ff @(posedge clk) begin
        if (state == s_idle && data_ready) begin
            ins_prefix <= data_in_prefix;
            ins_len <= data_in_len;
        end
    end

    // Own hash unit, never shared with lookups
    prefix_hash u_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (ins_prefix),
        .len    (ins_len),
        .hash   (ins_hash)
    );

    // Single write pulse, row from the hash and bit from the length
    assign wr_en = (state == s_write);
    assign wr_hash = ins_hash;
    assign wr_len = ins_len;

endmodule

`default_nettype wire

//--- hdl/fib_lookup.sv
// Lookup path of the FIB: longest-prefix match by probing decreasing lengths in the table
`timescale 1ns/1ps
`default_nettype none

module fib_lookup
    import fib_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              table_ready,
    input  wire              fib_out_bit,
    input  prefix_t          pit_in_prefix,
    input  len_t             pit_in_len,
    output logic             rd_en,
    output hash_t            rd_hash,
    input  wire [ROW_W-1:0]  rd_row,
    output prefix_t          longest_matching_prefix,
    output len_t             longest_matching_prefix_len,
    output logic             match_found,
    output logic             lookup_done
);

    typedef enum logic [1:0] {
        s_idle,
        s_hash,
        s_read,
        s_check
    } state_t;

    state_t state;

    // Request prefix and the length under probe
    prefix_t req_prefix;
    len_t cur_len;
    hash_t probe_hash;

    // Probe hits when the row bit of the current length is set
    logic hit;
    logic last_probe;

    // Length 0 never counts as a hit
    assign hit = (cur_len != '0) && rd_row[cur_len];
    // Nothing shorter left to try
    assign last_probe = (cur_len <= len_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            cur_len <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (fib_out_bit && table_ready) begin
                        cur_len <= pit_in_len;
                        state <= s_hash;
                    end
                end
                s_hash: begin
                    // Zero length goes straight to a no-match report
                    state <= (cur_len == '0) ? s_check : s_read;
                end
                s_read: begin
                    state <= s_check;
                end
                s_check: begin
                    if (hit || last_probe) begin
                        state <= s_idle;
                    end else begin
                        cur_len <= cur_len - 1'b1;
                        state <= s_hash;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && fib_out_bit) begin
            req_prefix <= pit_in_prefix;
        end
    end

    // Hash of the request masked to the current length
    prefix_hash u_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (req_prefix),
        .len    (cur_len),
        .hash   (probe_hash)
    );

    // Row read issued the cycle after the hash
    assign rd_en = (state == s_read);
    assign rd_hash = probe_hash;

    // Results valid in the check cycle that ends the search
    assign lookup_done = (state == s_check) && (hit || last_probe);
    assign match_found = (state == s_check) && hit;
    assign longest_matching_prefix = match_found ? prefix_mask(req_prefix, cur_len) : '0;
    assign longest_matching_prefix_len = match_found ? cur_len : '0;

endmodule

`default_nettype wire

//--- hdl/fib_pkg.sv
// Shared widths, sizes, types and prefix masking for the NDN FIB; imported by every RTL module
`default_nettype none

package fib_pkg;

    // Name prefix and length field
    localparam int PREFIX_W = 64;
    localparam int LEN_W = 6;

    // Hash and table geometry, one valid bit per length in each row
    localparam int HASH_W = 10;
    localparam int TABLE_DEPTH = 1024;
    localparam int ROW_W = 1 << LEN_W;

    // XOR fold splits the prefix into this many hash-wide chunks
    localparam int HASH_CHUNKS = (PREFIX_W + HASH_W - 1) / HASH_W;
    localparam int FOLD_W = HASH_CHUNKS * HASH_W;

    // Payload stream of an accepted data packet
    localparam int DATA_W = 8;
    localparam int DATA_BYTES = 1024;
    localparam int BYTE_CNT_W = $clog2(DATA_BYTES);

    typedef logic [PREFIX_W-1:0] prefix_t;
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [HASH_W-1:0] hash_t;

    // Keep the top len bits of a prefix, clear the rest
    function automatic prefix_t prefix_mask(input prefix_t prefix, input len_t len);
        return prefix & ~({PREFIX_W{1'b1}} >> len);
    endfunction

endpackage

`default_nettype wire

//--- hdl/fib_table.sv
// Valid-bit store of the FIB, cleared by a sweep after reset, one write and one read port
`timescale 1ns/1ps
`default_nettype none

module fib_table
    import fib_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              wr_en,
    input  hash_t            wr_hash,
    input  len_t             wr_len,
    input  wire              rd_en,
    input  hash_t            rd_hash,
    output logic [ROW_W-1:0] rd_row,
    output logic             table_ready
);

    // One row per hash value, one bit per prefix length
    logic [ROW_W-1:0] mem [TABLE_DEPTH];

    // Row being cleared by the sweep
    hash_t clr_row;

    // Sweep takes one row per cycle, ready rises after the last row
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_row <= '0;
            table_ready <= 1'b0;
        end else if (!table_ready) begin
            clr_row <= clr_row + 1'b1;
            if (clr_row == HASH_W'(TABLE_DEPTH - 1)) begin
                table_ready <= 1'b1;
            end
        end
    end

    // Write port is shared with the sweep, sweep has priority
    always_ff @(posedge clk) begin
        if (!table_ready) begin
            mem[clr_row] <= '0;
        end else if (wr_en) begin
            // Only the addressed length bit is set
            mem[wr_hash][wr_len] <= 1'b1;
        end
    end

    // Whole row out one cycle later, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_row <= mem[rd_hash];
        end
    end

endmodule

`default_nettype wire

//--- hdl/ndn_fib.sv
// Top level of the NDN FIB: table store, insertion, lookup and forwarding side by side
`timescale 1ns/1ps
`default_nettype none

module ndn_fib
    import fib_pkg::*;
(
    input  wire               clk,
    input  wire               rst,

    // Data packet arrival
    input  wire               data_ready,
    input  prefix_t           data_in_prefix,
    input  len_t              data_in_len,
    input  wire [DATA_W-1:0]  data_in,

    // Interest lookup request from the PIT
    input  wire               fib_out_bit,
    input  prefix_t           pit_in_prefix,
    input  len_t              pit_in_len,

    // PIT decision on an offered data prefix
    input  wire               rejected,
    input  wire               start_send_to_pit,

    output logic              ready,

    // Offer to the PIT and payload stream
    output logic              prefix_ready,
    output prefix_t           pit_out_prefix,
    output len_t              pit_out_len,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic              out_last,

    // Lookup result
    output logic              lookup_done,
    output prefix_t           longest_matching_prefix,
    output len_t              longest_matching_prefix_len,
    output logic              match_found
);

    // Table write port from insertion
    logic wr_en;
    hash_t wr_hash;
    len_t wr_len;

    // Table read port from lookup
    logic rd_en;
    hash_t rd_hash;
    logic [ROW_W-1:0] rd_row;

    // Clear-sweep done flag doubles as the ready output
    fib_table u_table (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_hash     (wr_hash),
        .wr_len      (wr_len),
        .rd_en       (rd_en),
        .rd_hash     (rd_hash),
        .rd_row      (rd_row),
        .table_ready (ready)
    );

    fib_insert u_insert (
        .clk            (clk),
        .rst            (rst),
        .table_ready    (ready),
        .data_ready     (data_ready),
        .data_in_prefix (data_in_prefix),
        .data_in_len    (data_in_len),
        .wr_en          (wr_en),
        .wr_hash        (wr_hash),
        .wr_len         (wr_len)
    );

    fib_lookup u_lookup (
        .clk                         (clk),
        .rst                         (rst),
        .table_ready                 (ready),
        .fib_out_bit                 (fib_out_bit),
        .pit_in_prefix               (pit_in_prefix),
        .pit_in_len                  (pit_in_len),
        .rd_en                       (rd_en),
        .rd_hash                     (rd_hash),
        .rd_row                      (rd_row),
        .longest_matching_prefix     (longest_matching_prefix),
        .longest_matching_prefix_len (longest_matching_prefix_len),
        .match_found                 (match_found),
        .lookup_done                 (lookup_done)
    );

    // Same arrival strobe as the insertion path
    data_forward u_forward (
        .clk               (clk),
        .rst               (rst),
        .data_ready        (data_ready),
        .data_in_prefix    (data_in_prefix),
        .data_in_len       (data_in_len),
        .rejected          (rejected),
        .start_send_to_pit (start_send_to_pit),
        .data_in           (data_in),
        .pit_out_prefix    (pit_out_prefix),
        .pit_out_len       (pit_out_len),
        .prefix_ready      (prefix_ready),
        .out_data          (out_data),
        .out_valid         (out_valid),
        .out_last          (out_last)
    );

endmodule

`default_nettype wire

//--- hdl/prefix_hash.sv
// Registered XOR-fold hash of a length-masked prefix, one per FIB path, one cycle of latency
`timescale 1ns/1ps
`default_nettype none

module prefix_hash
    import fib_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  prefix_t prefix,
    input  len_t    len,
    output hash_t   hash
);

    // Masked prefix zero-extended to a whole number of chunks
    logic [FOLD_W-1:0] padded;
    hash_t folded;

    always_comb begin
        // Top chunk picks up the zero padding
        padded = FOLD_W'(prefix_mask(prefix, len));
        folded = '0;
        for (int i = 0; i < HASH_CHUNKS; i++) begin
            folded ^= padded[i*HASH_W +: HASH_W];
        end
        // Mix in the length so nested prefixes spread over rows
        folded[LEN_W-1:0] ^= len;
    end

    // Result is ready the cycle after the inputs
    always_ff @(posedge clk) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= folded;
        end
    end

endmodule

`default_nettype wire

//--- ndn_fib.f
hdl/fib_pkg.sv
hdl/prefix_hash.sv
hdl/fib_table.sv
hdl/fib_insert.sv
hdl/fib_lookup.sv
hdl/data_forward.sv
hdl/ndn_fib.sv
verif/ndn_fib_sva.sv
verif/tb_ndn_fib.sv

//--- verif/ndn_fib_sva.sv
// Concurrent checks on the FIB top-level outputs, bound into every ndn_fib instance
`timescale 1ns/1ps
`default_nettype none

module ndn_fib_sva
    import fib_pkg::*;
(
    input wire  clk,
    input wire  rst,
    input wire  prefix_ready,
    input wire  lookup_done,
    input wire  out_valid,
    input wire  out_last,
    input wire  match_found,
    input len_t longest_matching_prefix_len
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Offer to the PIT lasts one cycle
    a_offer_pulse: assert property (@(posedge clk) disable iff (rst)
        prefix_ready |=> !prefix_ready)
    else begin
        fail_count++;
        $error("prefix_ready stayed high for more than one cycle");
    end

    // Lookup result lasts one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        lookup_done |=> !lookup_done)
    else begin
        fail_count++;
        $error("lookup_done stayed high for more than one cycle");
    end

    // Last byte flag only inside a transfer
    a_last_in_xfer: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid)
    else begin
        fail_count++;
        $error("out_last seen without out_valid");
    end

    // Offer and payload come from different states
    a_offer_vs_xfer: assert property (@(posedge clk) disable iff (rst)
        !(out_valid && prefix_ready))
    else begin
        fail_count++;
        $error("out_valid and prefix_ready high together");
    end

    // A hit never has length 0
    a_match_len: assert property (@(posedge clk) disable iff (rst)
        match_found |-> longest_matching_prefix_len != '0)
    else begin
        fail_count++;
        $error("match_found with a zero result length");
    end

endmodule

bind ndn_fib ndn_fib_sva u_sva (
    .clk                         (clk),
    .rst                         (rst),
    .prefix_ready                (prefix_ready),
    .lookup_done                 (lookup_done),
    .out_valid                   (out_valid),
    .out_last                    (out_last),
    .match_found                 (match_found),
    .longest_matching_prefix_len (longest_matching_prefix_len)
);

`default_nettype wire

//--- verif/tb_ndn_fib.sv
// Self-checking testbench for the NDN FIB; compile with ndn_fib.f and run tb_ndn_fib as top
`timescale 1ns/1ps
`default_nettype none

module tb_ndn_fib
    import fib_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] SEED = 32'h7c7d612b;
    // Planned traffic, used to size the watchdog
    localparam int N_LOOKUPS = 73;
    localparam int N_PACKETS = 48;
    localparam int LOOKUP_BOUND = 64 * 3 + 4;
    localparam int PACKET_BOUND = DATA_BYTES + 10;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + TABLE_DEPTH
        + N_LOOKUPS * LOOKUP_BOUND + N_PACKETS * PACKET_BOUND);

    logic clk = 1'b0;
    logic rst;
    logic data_ready, fib_out_bit, rejected, start_send_to_pit;
    prefix_t data_in_prefix, pit_in_prefix;
    len_t data_in_len, pit_in_len;
    logic [DATA_W-1:0] data_in;
    logic ready, prefix_ready, out_valid, out_last, lookup_done, match_found;
    prefix_t pit_out_prefix, longest_matching_prefix;
    len_t pit_out_len, longest_matching_prefix_len;
    logic [DATA_W-1:0] out_data;

    // Run bookkeeping
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int test_err_base = 0;
    int done_count = 0;
    int byte_count = 0;
    int last_count = 0;
    int burst_len = 0;
    logic [DATA_W-1:0] prev_in = '0;

    // Expected lookup results as {found, len, prefix}, oldest first
    logic [PREFIX_W+LEN_W:0] exp_q [$];
    // Mirror of the valid-bit table
    bit [ROW_W-1:0] ref_table [TABLE_DEPTH];
    prefix_t ins_p [$];
    len_t ins_l [$];

    ndn_fib u_dut (
        .clk                         (clk),
        .rst                         (rst),
        .data_ready                  (data_ready),
        .data_in_prefix              (data_in_prefix),
        .data_in_len                 (data_in_len),
        .data_in                     (data_in),
        .fib_out_bit                 (fib_out_bit),
        .pit_in_prefix               (pit_in_prefix),
        .pit_in_len                  (pit_in_len),
        .rejected                    (rejected),
        .start_send_to_pit           (start_send_to_pit),
        .ready                       (ready),
        .prefix_ready                (prefix_ready),
        .pit_out_prefix              (pit_out_prefix),
        .pit_out_len                 (pit_out_len),
        .out_valid                   (out_valid),
        .out_data                    (out_data),
        .out_last                    (out_last),
        .lookup_done                 (lookup_done),
        .longest_matching_prefix     (longest_matching_prefix),
        .longest_matching_prefix_len (longest_matching_prefix_len),
        .match_found                 (match_found)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Top len bits kept, counted from the MSB
    function automatic prefix_t mask_to_len(input prefix_t p, input len_t l);
        prefix_t m;
        m = '0;
        for (int i = 0; i < PREFIX_W; i++) begin
            if (i >= PREFIX_W - int'(l)) begin
                m[i] = p[i];
            end
        end
        return m;
    endfunction

    // XOR of 10-bit chunks of the masked prefix, length mixed into the low bits
    function automatic hash_t fold_hash(input prefix_t p, input len_t l);
        logic [HASH_CHUNKS*HASH_W-1:0] pad;
        hash_t h;
        pad = {{(HASH_CHUNKS*HASH_W-PREFIX_W){1'b0}}, mask_to_len(p, l)};
        h = '0;
        for (int c = 0; c < HASH_CHUNKS; c++) begin
            h ^= pad[c*HASH_W +: HASH_W];
        end
        h[LEN_W-1:0] ^= l;
        return h;
    endfunction

    // First hit walking down from the request length
    function automatic logic [PREFIX_W+LEN_W:0] expected_lookup(input prefix_t p, input len_t l);
        for (int k = int'(l); k >= 1; k--) begin
            if (ref_table[fold_hash(p, len_t'(k))][k]) begin
                return {1'b1, len_t'(k), mask_to_len(p, len_t'(k))};
            end
        end
        return '0;
    endfunction

    function automatic prefix_t random_prefix();
        return {$urandom, $urandom};
    endfunction

    // Compare each lookup result with the value queued at request time
    always @(posedge clk) begin
        logic [PREFIX_W+LEN_W:0] exp;
        if (lookup_done) begin
            done_count++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Error at %0t ns: lookup_done without a pending request", $time);
            end else begin
                exp = exp_q.pop_front();
                check(match_found, exp[PREFIX_W+LEN_W], "match_found");
                check(longest_matching_prefix_len, exp[PREFIX_W +: LEN_W], "result length");
                check(longest_matching_prefix, exp[PREFIX_W-1:0], "result prefix");
            end
        end
    end

    // Payload capture, each byte is data_in of the cycle before
    always @(posedge clk) begin
        if (out_valid) begin
            burst_len++;
            byte_count++;
            check(out_data, prev_in, "payload byte");
            if (out_last) begin
                last_count++;
                check(burst_len, DATA_BYTES, "out_last position");
            end
        end else begin
            burst_len = 0;
        end
        prev_in = data_in;
    end

    // Arrival, offer check, then PIT decision on the third cycle
    task automatic send_packet(input prefix_t p, input len_t l, input bit accept);
        int bytes0;
        int lasts0;
        int waited;
        bytes0 = byte_count;
        lasts0 = last_count;
        @(negedge clk);
        data_ready = 1'b1;
        data_in_prefix = p;
        data_in_len = l;
        @(negedge clk);
        data_ready = 1'b0;
        check(prefix_ready, 1'b1, "prefix_ready after arrival");
        check(pit_out_prefix, p, "pit_out_prefix");
        check(pit_out_len, l, "pit_out_len");
        // Every nonzero length gets its bit set
        if (l != '0) begin
            ref_table[fold_hash(p, l)][l] = 1'b1;
        end
        @(negedge clk);
        start_send_to_pit = accept;
        rejected = !accept;
        @(negedge clk);
        start_send_to_pit = 1'b0;
        rejected = 1'b0;
        waited = 0;
        if (accept) begin
            while (byte_count - bytes0 < DATA_BYTES && waited < PACKET_BOUND) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= PACKET_BOUND) begin
                error_count++;
                $display("Error at %0t ns: payload stream did not complete", $time);
            end
        end else begin
            repeat (4) @(negedge clk);
        end
        @(negedge clk);
        check(byte_count - bytes0, accept ? DATA_BYTES : 0, "payload byte count");
        check(last_count - lasts0, accept ? 1 : 0, "out_last count");
        check(out_valid, 1'b0, "out_valid after packet");
    endtask

    task automatic lookup(input prefix_t p, input len_t l);
        int done0;
        int waited;
        exp_q.push_back(expected_lookup(p, l));
        done0 = done_count;
        @(negedge clk);
        fib_out_bit = 1'b1;
        pit_in_prefix = p;
        pit_in_len = l;
        @(negedge clk);
        fib_out_bit = 1'b0;
        waited = 0;
        while (done_count == done0 && waited < LOOKUP_BOUND) begin
            @(negedge clk);
            waited++;
        end
        if (done_count == done0) begin
            error_count++;
            $display("Error at %0t ns: lookup of length %0d never finished", $time, l);
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("Test %0d %-15s done, %0d errors", test_count, name,
            error_count - test_err_base);
        test_err_base = error_count;
    endtask

    initial begin
        len_t nest_len [4];
        len_t req_len [10];
        prefix_t p;
        len_t l;
        int n;
        int idx;
        nest_len = '{8, 16, 24, 40};
        req_len = '{63, 40, 39, 24, 20, 16, 9, 8, 7, 0};
        rst = 1'b1;
        data_ready = 1'b0;
        data_in_prefix = '0;
        data_in_len = '0;
        data_in = '0;
        fib_out_bit = 1'b0;
        pit_in_prefix = '0;
        pit_in_len = '0;
        rejected = 1'b0;
        start_send_to_pit = 1'b0;
        void'($urandom(SEED));
        // Fresh payload byte every cycle
        fork
            forever begin
                @(negedge clk);
                data_in = DATA_W'($urandom);
            end
        join_none
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Clear sweep, then a lookup on the empty table
        n = 0;
        while (!ready && n < TABLE_DEPTH + 16) begin
            @(negedge clk);
            n++;
            check(prefix_ready | out_valid | out_last | lookup_done, 1'b0,
                "control outputs during clear");
        end
        check(n, TABLE_DEPTH, "clear sweep cycles");
        lookup(random_prefix(), 6'd63);
        end_test("clear");

        p = random_prefix();
        send_packet(p, 6'd37, 1'b0);
        lookup(p, 6'd37);
        end_test("exact match");

        // Nested lengths of one prefix, low bits varied per request
        p = random_prefix();
        foreach (nest_len[i]) begin
            send_packet(p, nest_len[i], 1'b0);
        end
        foreach (req_len[i]) begin
            lookup(p ^ (random_prefix() >> 40), req_len[i]);
        end
        end_test("longest match");

        for (int i = 0; i < 40; i++) begin
            p = random_prefix();
            l = len_t'($urandom);
            send_packet(p, l, 1'b0);
            ins_p.push_back(p);
            ins_l.push_back(l);
        end
        // Half the requests extend an inserted entry
        for (int i = 0; i < 60; i++) begin
            if ($urandom % 2 == 0) begin
                idx = $urandom % ins_p.size();
                p = ins_p[idx] ^ (random_prefix() >> ins_l[idx]);
                l = len_t'(ins_l[idx] + $urandom % (64 - ins_l[idx]));
            end else begin
                p = random_prefix();
                l = len_t'($urandom);
            end
            lookup(p, l);
        end
        end_test("random traffic");

        send_packet(random_prefix(), len_t'($urandom_range(1, 63)), 1'b1);
        end_test("accepted fwd");

        // Dropped packet, then an accepted one that must be in the table
        send_packet(random_prefix(), len_t'($urandom_range(1, 63)), 1'b0);
        p = random_prefix();
        l = len_t'($urandom_range(1, 63));
        send_packet(p, l, 1'b1);
        lookup(p, l);
        end_test("rejected fwd");

        error_count += u_dut.u_sva.fail_count;
        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
            error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Bound on the whole run, twice the worst case of the planned traffic
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
